//--- bench/riscCoreGolden.txt
# Columns are a tag and two hex fields. I addr word is a program word, D addr word a data word.
# W addr data is an expected bus write in order, P id pcNext an expected pause and its resume address.
I 0000 0000
I 0001 7123
I 0002 5100
I 0003 4200
I 0004 5101
I 0005 1102
I 0006 4201
I 0007 3011
I 0008 F0F0
I 0009 5102
I 000A 4202
I 000B 2000
I 000C 1200
I 000D 4203
I 000E 3ABC
I 000F 5103
I 0010 1101
I 0011 4204
I 0012 6FFF
I 0013 3FFE
# Data preload.
D 0100 1234
D 0101 ABCD
D 0102 5A5A
D 0103 8001
# Writes up to the first pause.
W 0200 1234
W 0102 ABCD
W 0201 5A5A
P 0011 0008
# A later LDR sees the swapped-in word.
W 0202 ABCD
W 0200 ABCD
W 0203 1234
P 0ABC 000F
W 0101 8001
W 0204 ABCD
# Final pause ends the program.
P 0FFE 0014

//--- vlog.f
rtl/coreBusPkg.sv
rtl/coreIsaPkg.sv
rtl/coreMemController.sv
rtl/coreFetchPipe.sv
rtl/coreExecute.sv
rtl/riscCore.sv
bench/riscCoreTb.sv

//--- runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module riscCoreTb -f vlog.f \
    -Mdir obj_dir > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/VriscCoreTb > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0

//--- bench/riscCoreTb.sv
`timescale 1ns/1ps

module riscCoreTb
    import coreBusPkg::*, coreIsaPkg::*;
();

    localparam int CLK_HALF_NS = 20;
    localparam int CYCLE_NS    = 2 * CLK_HALF_NS;
    localparam int RST_CYCLES  = 8;
    localparam int MEM_WORDS   = 1 << ADDR_W;

    // DUT ports.
    logic               clk = 1'b0;
    logic               rst;
    logic               isBooted;
    logic               startPause;
    logic [WORD_W-1:0]  memRData;
    logic [ADDR_W-1:0]  memAddr;
    logic [WORD_W-1:0]  memWData;
    logic               memWr;
    logic               doPause;
    logic               nowPaused;
    logic [FIELD_W-1:0] pauseId;

    // Memory model and golden expectations.
    logic [WORD_W-1:0]  mem [MEM_WORDS];
    logic [ADDR_W-1:0]  expWrAddr[$];
    logic [WORD_W-1:0]  expWrData[$];
    logic [FIELD_W-1:0] expPauseId[$];
    logic [ADDR_W-1:0]  expPauseNext[$];

    // Run bookkeeping.
    logic [31:0]        lfsrState  = 32'h4007fdb2;
    int                 instrCount = 0;
    int                 pauseCount = 0;
    int                 limitNs    = 0;
    logic               allDone    = 1'b0;
    logic               inPause    = 1'b0;
    logic               startWas   = 1'b0;
    logic [ADDR_W-1:0]  resumeAt   = '0;

    riscCore #(
        .MEM_ADDR_W(ADDR_W)
    ) dut0 (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_isBooted   (isBooted),
        .i_startPause (startPause),
        .o_doPause    (doPause),
        .o_nowPaused  (nowPaused),
        .o_pauseId    (pauseId),
        .i_memRData   (memRData),
        .o_memAddr    (memAddr),
        .o_memWData   (memWData),
        .o_memWr      (memWr)
    );

    always #(CLK_HALF_NS) clk = ~clk;

    // Single-port memory with a combinational read and a write at the clock edge.
    assign memRData = mem[memAddr];

    always @(posedge clk) begin
        if (memWr) begin
            mem[memAddr] <= memWData;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers.
    // ------------------------------------------------------------------------

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit.
    task automatic takeBits(input int n, output int v);
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsrState[0]);
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic checkWrite(input logic [ADDR_W-1:0] gotAddr, input logic [WORD_W-1:0] gotData,
                              input logic [ADDR_W-1:0] expAddr, input logic [WORD_W-1:0] expData);
        if (gotAddr !== expAddr || gotData !== expData) begin
            abortRun($sformatf("Fail %0t ns: write [%h] = %h, expected [%h] = %h",
                               $time, gotAddr, gotData, expAddr, expData));
        end
    endtask

    task automatic checkPauseId(input logic [FIELD_W-1:0] got, input logic [FIELD_W-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %0t ns: pause id %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic checkFetchAddr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %0t ns: fetch address %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic checkPausedFlag(input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %0t ns: paused flag %b, expected %b", $time, got, exp));
        end
    endtask

    // Tag I is a program word, D a data word, W an expected write, P an expected pause.
    task automatic loadGolden();
        int            fd;
        int            n;
        logic [63:0]   tag;
        logic [1023:0] rest;
        logic [31:0]   a;
        logic [31:0]   v;
        fd = $fopen("bench/riscCoreGolden.txt", "r");
        if (fd == 0) begin
            abortRun("Could not open the golden file bench/riscCoreGolden.txt.");
        end else begin
            while (!$feof(fd)) begin
                tag = '0;
                n = $fscanf(fd, "%s", tag);
                if (n != 1) begin
                    break;
                end
                if (tag == "#") begin
                    n = $fgets(rest, fd);
                end else if ($fscanf(fd, "%h %h", a, v) != 2) begin
                    abortRun("A golden record is missing its two hex fields.");
                end else if (tag == "I" || tag == "D") begin
                    mem[a[ADDR_W-1:0]] <= v[WORD_W-1:0];
                    instrCount += (tag == "I") ? 1 : 0;
                end else if (tag == "W") begin
                    expWrAddr.push_back(a[ADDR_W-1:0]);
                    expWrData.push_back(v[WORD_W-1:0]);
                end else if (tag == "P") begin
                    expPauseId.push_back(a[FIELD_W-1:0]);
                    expPauseNext.push_back(v[ADDR_W-1:0]);
                    pauseCount++;
                end else begin
                    abortRun("The golden file holds an unknown record type.");
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------------------
    // Reset, boot and end of run.
    // ------------------------------------------------------------------------

    initial begin : mainFlow
        int a;
        int bootWait;
        rst        = 1'b1;
        isBooted   = 1'b0;
        startPause = 1'b0;
        // Spare words read back their own address, so low memory decodes as NOP.
        for (a = 0; a < MEM_WORDS; a++) begin
            mem[a] <= WORD_W'(a);
        end
        loadGolden();
        limitNs = CYCLE_NS * (6 * instrCount + 30 * pauseCount + RST_CYCLES + 8);
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        takeBits(3, bootWait);
        repeat (bootWait) @(posedge clk);
        isBooted <= 1'b1;
        wait (allDone);
        repeat (2) @(posedge clk);
        $display("Regression passed");
        $finish;
    end

    // MCU grants a pause after 0 to 15 cycles and holds it 1 to 8 cycles.
    initial begin : mcuModel
        int waitCycles;
        int holdCycles;
        forever begin
            @(negedge clk);
            if (doPause && !startPause) begin
                takeBits(4, waitCycles);
                takeBits(3, holdCycles);
                repeat (waitCycles + 1) @(posedge clk);
                startPause <= 1'b1;
                repeat (holdCycles + 1) @(posedge clk);
                startPause <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (limitNs > 0);
        #(limitNs);
        abortRun("The run timed out before the program reached its last pause.");
    end

    // ------------------------------------------------------------------------
    // Bus and pause checks sampled mid-cycle.
    // ------------------------------------------------------------------------

    always @(negedge clk) begin : busMonitor
        logic [ADDR_W-1:0]  wantAddr;
        logic [WORD_W-1:0]  wantData;
        logic [FIELD_W-1:0] wantId;
        // Core parks at word 0 until boot is done.
        if (!isBooted) begin
            checkFetchAddr(memAddr, '0);
            if (memWr) begin
                abortRun("The core wrote memory before boot finished.");
            end
        end
        if (!rst) begin
            checkPausedFlag(nowPaused, startPause);
        end
        if (memWr) begin
            if (nowPaused) begin
                abortRun("The core wrote memory while paused.");
            end else if (expWrAddr.size() == 0) begin
                abortRun("The core wrote memory more often than expected.");
            end else begin
                wantAddr = expWrAddr.pop_front();
                wantData = expWrData.pop_front();
                checkWrite(memAddr, memWData, wantAddr, wantData);
            end
        end
        // PSE just reached the pipe and the PC already points past it.
        if (doPause && !inPause) begin
            inPause = 1'b1;
            if (expPauseId.size() == 0) begin
                abortRun("The core paused more often than expected.");
            end else begin
                wantId   = expPauseId.pop_front();
                resumeAt = expPauseNext.pop_front();
                checkPauseId(pauseId, wantId);
                checkFetchAddr(memAddr, resumeAt);
                if (expPauseId.size() == 0 && expWrAddr.size() != 0) begin
                    abortRun("The program ended with expected writes still missing.");
                end
            end
        end
        // First cycle after release fetches the word after the PSE.
        if (inPause && startWas && !startPause) begin
            checkFetchAddr(memAddr, resumeAt);
            inPause = 1'b0;
            if (expPauseId.size() == 0) begin
                allDone = 1'b1;
            end
        end
        startWas = startPause;
    end

endmodule

//--- rtl/riscCore.sv
`timescale 1ns/1ps

module riscCore
    import coreBusPkg::*, coreIsaPkg::*;
#(
    parameter int MEM_ADDR_W = 15
) (
    input  logic               i_clk,
    input  logic               i_rst,
    // MCU state.
    input  logic               i_isBooted,
    input  logic               i_startPause,
    output logic               o_doPause,
    output logic               o_nowPaused,
    output logic [FIELD_W-1:0] o_pauseId,
    // External memory bus.
    input  logic [WORD_W-1:0]  i_memRData,
    output logic [ADDR_W-1:0]  o_memAddr,
    output logic [WORD_W-1:0]  o_memWData,
    output logic               o_memWr
);

    // Fetch side.
    logic [ADDR_W-1:0] pc;
    logic              iBusy;
    pipeReg_t          pipe;
    // Data side.
    dataReq_t          dReq;
    dataStat_t         dStat;
    // Hazard controls.
    logic              stall;
    logic              freeze;
    logic              pauseGrant;

    // ------------------------------------------------------------------------
    // Memory controller shares the bus between fetch and data.
    // ------------------------------------------------------------------------

    coreMemController #(
        .MEM_ADDR_W(MEM_ADDR_W)
    ) memCtrl0 (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_iAddr    (pc),
        .o_iBusy    (iBusy),
        .i_dReq     (dReq),
        .o_dStat    (dStat),
        .i_memRData (i_memRData),
        .o_memAddr  (o_memAddr),
        .o_memWData (o_memWData),
        .o_memWr    (o_memWr)
    );

    // ------------------------------------------------------------------------
    // FETCH stage and pipeline register.
    // ------------------------------------------------------------------------

    coreFetchPipe #(
        .MEM_ADDR_W(MEM_ADDR_W)
    ) fetch0 (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_isBooted   (i_isBooted),
        .i_memRData   (i_memRData),
        .i_iBusy      (iBusy),
        .i_stall      (stall),
        .i_freeze     (freeze),
        .i_pauseGrant (pauseGrant),
        .o_pc         (pc),
        .o_pipe       (pipe)
    );

    // EXECUTE/MEMORY stage.
    coreExecute exec0 (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_pipe       (pipe),
        .i_startPause (i_startPause),
        .i_dStat      (dStat),
        .i_memRData   (i_memRData),
        .o_dReq       (dReq),
        .o_stall      (stall),
        .o_freeze     (freeze),
        .o_pauseGrant (pauseGrant),
        .o_doPause    (o_doPause),
        .o_nowPaused  (o_nowPaused),
        .o_pauseId    (o_pauseId)
    );

endmodule

//--- rtl/coreExecute.sv
`timescale 1ns/1ps

module coreExecute
    import coreBusPkg::*, coreIsaPkg::*;
(
    input  logic               i_clk,
    input  logic               i_rst,
    input  pipeReg_t           i_pipe,
    input  logic               i_startPause,
    input  dataStat_t          i_dStat,
    input  logic [WORD_W-1:0]  i_memRData,
    output dataReq_t           o_dReq,
    // Hazard controls for the fetch pipe.
    output logic               o_stall,
    output logic               o_freeze,
    output logic               o_pauseGrant,
    // MCU pause handshake.
    output logic               o_doPause,
    output logic               o_nowPaused,
    output logic [FIELD_W-1:0] o_pauseId
);

    logic [WORD_W-1:0] acc;
    logic [WORD_W-1:0] accSave;
    opcode_e           memOp;
    logic              isLdr;
    logic              isStr;
    logic              isSwp;
    logic              isMem;
    logic              isPse;

    // ------------------------------------------------------------------------
    // Decode.
    // ------------------------------------------------------------------------

    assign memOp = i_pipe.instr.mem.op;
    assign isLdr = (memOp == OP_LDR);
    assign isStr = (memOp == OP_STR);
    assign isSwp = (memOp == OP_SWP);
    assign isMem = isLdr | isStr | isSwp;
    assign isPse = (i_pipe.instr.pause.op == OP_PSE);

    // ------------------------------------------------------------------------
    // Accumulator.
    // ------------------------------------------------------------------------

    // Loads and swaps take the word read on the bus.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            acc <= '0;
        end else if (i_dStat.reading) begin
            acc <= i_memRData;
        end
    end

    // Snapshot for the write word.
    // Frozen for the whole access, so a swap writes the old value.
    always_ff @(posedge i_clk) begin
        if (!isMem) begin
            accSave <= acc;
        end
    end

    // ------------------------------------------------------------------------
    // Data request.
    // ------------------------------------------------------------------------

    always_comb begin
        o_dReq.en    = isMem;
        o_dReq.wr    = isStr;
        o_dReq.swp   = isSwp;
        o_dReq.addr  = ADDR_W'(i_pipe.instr.mem.addr);
        o_dReq.wdata = accSave;
    end

    // ------------------------------------------------------------------------
    // Hazards and pause.
    // ------------------------------------------------------------------------

    // PC holds for pauses and for instructions still in the pipe.
    assign o_stall = i_startPause | isPse | isMem;
    // PSE waits for the MCU, memory ops wait for done.
    assign o_freeze = (isPse & ~i_startPause) | (isMem & ~i_dStat.done);
    // MCU grant replaces the pipe entry by a bubble.
    assign o_pauseGrant = i_startPause;

    assign o_doPause   = isPse;
    assign o_pauseId   = i_pipe.instr.pause.id;
    // Paused once the pipe holds only a bubble or the waiting PSE.
    assign o_nowPaused = i_startPause & (i_pipe.clear | isPse);

    // ------------------------------------------------------------------------
    // Checks.
    // ------------------------------------------------------------------------

    // Controller sees one steady request until the access finishes.
    aReqStable : assert property (@(posedge i_clk) disable iff (i_rst)
        (o_dReq.en && !i_dStat.done) |=> $stable(o_dReq))
        else $error("Data request changed before done.");

endmodule

//--- rtl/coreFetchPipe.sv
`timescale 1ns/1ps

module coreFetchPipe
    import coreBusPkg::*, coreIsaPkg::*;
#(
    parameter int MEM_ADDR_W = 15
) (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_isBooted,
    // Fetched word is valid unless the bus is busy with data.
    input  logic [WORD_W-1:0] i_memRData,
    input  logic              i_iBusy,
    // Hazard controls from the execute stage.
    input  logic              i_stall,
    input  logic              i_freeze,
    input  logic              i_pauseGrant,
    output logic [ADDR_W-1:0] o_pc,
    output pipeReg_t          o_pipe
);

    logic [MEM_ADDR_W-1:0] pcQ;
    logic [MEM_ADDR_W-1:0] pcInc;
    pipeReg_t              pipeD;
    pipeReg_t              pipeQ;
    logic                  clearNext;

    // ------------------------------------------------------------------------
    // Program counter.
    // ------------------------------------------------------------------------

    // Next sequential word address.
    assign pcInc = pcQ + 1'b1;

    // Core waits at address 0 until boot is finished.
    always_ff @(posedge i_clk) begin
        if (i_rst || !i_isBooted) begin
            pcQ <= '0;
        end else if (!i_stall) begin
            pcQ <= pcInc;
        end
    end

    // Upper address bits stay zero.
    assign o_pc = ADDR_W'(pcQ);

    // ------------------------------------------------------------------------
    // Pipeline register.
    // ------------------------------------------------------------------------

    // Bubble when the word on the bus was data or a pause is taken.
    assign clearNext = i_iBusy | i_pauseGrant;

    always_comb begin
        pipeD.clear  = clearNext;
        pipeD.pcNext = ADDR_W'(pcInc);
        pipeD.instr  = instr_u'(i_memRData);
    end

    // Held as a bubble while booting.
    // Freeze keeps the executing instruction in place.
    always_ff @(posedge i_clk) begin
        if (i_rst || !i_isBooted) begin
            pipeQ <= PIPE_CLEARED;
        end else if (!i_freeze) begin
            pipeQ <= pipeD;
        end
    end

    // Cleared entries execute as NOP.
    always_comb begin
        o_pipe = pipeQ;
        if (pipeQ.clear) begin
            o_pipe.instr.mem.op = OP_NOP;
        end
    end

    // ------------------------------------------------------------------------
    // Checks.
    // ------------------------------------------------------------------------

    // A memory op, a PSE or a granted pause in the pipe holds the fetch address.
    aPcHoldsOnStall : assert property (@(posedge i_clk) disable iff (i_rst)
        (i_isBooted && (i_pauseGrant
            || (o_pipe.instr.mem.op inside {OP_SWP, OP_PSE, OP_STR, OP_LDR})))
        |=> $stable(pcQ))
        else $error("PC moved during a stall.");

endmodule

//--- rtl/coreMemController.sv
`timescale 1ns/1ps

module coreMemController
    import coreBusPkg::*;
#(
    parameter int MEM_ADDR_W = 15
) (
    input  logic              i_clk,
    input  logic              i_rst,
    // Instruction side always reads.
    input  logic [ADDR_W-1:0] i_iAddr,
    output logic              o_iBusy,
    // Data side.
    input  dataReq_t          i_dReq,
    output dataStat_t         o_dStat,
    // External single-port memory.
    input  logic [WORD_W-1:0] i_memRData,
    output logic [ADDR_W-1:0] o_memAddr,
    output logic [WORD_W-1:0] o_memWData,
    output logic              o_memWr
);

    // Bus owner for the current cycle.
    localparam logic [1:0] ST_FETCH = 2'd0;
    localparam logic [1:0] ST_READ  = 2'd1;
    localparam logic [1:0] ST_WRITE = 2'd2;

    logic [1:0]        state;
    logic [1:0]        stateNext;
    logic              dataPhase;
    logic [ADDR_W-1:0] busAddr;

    // ------------------------------------------------------------------------
    // Bus scheduling.
    // ------------------------------------------------------------------------

    // A request seen while fetching takes the bus on the next cycle.
    // Stores go straight to the write cycle while loads and swaps read first.
    always_comb begin
        stateNext = state;
        case (state)
            ST_FETCH: begin
                if (i_dReq.en) begin
                    stateNext = i_dReq.wr ? ST_WRITE : ST_READ;
                end
            end
            // Swap writes back the old word after its read.
            ST_READ:  stateNext = i_dReq.swp ? ST_WRITE : ST_FETCH;
            ST_WRITE: stateNext = ST_FETCH;
            default:  stateNext = ST_FETCH;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= ST_FETCH;
        end else begin
            state <= stateNext;
        end
    end

    // ------------------------------------------------------------------------
    // Bus outputs and status.
    // ------------------------------------------------------------------------

    assign dataPhase = (state != ST_FETCH);

    // Data address wins whenever the bus is not fetching.
    assign busAddr = dataPhase ? i_dReq.addr : i_iAddr;

    // Only the used address bits reach the pins.
    assign o_memAddr  = ADDR_W'(busAddr[MEM_ADDR_W-1:0]);
    assign o_memWData = i_dReq.wdata;
    assign o_memWr    = (state == ST_WRITE);

    // Fetched word is not an instruction during a data cycle.
    assign o_iBusy = dataPhase;

    assign o_dStat.reading = (state == ST_READ);
    // Load ends on its read while store and swap end on the write.
    assign o_dStat.done = ((state == ST_READ) && !i_dReq.swp) || (state == ST_WRITE);

    // ------------------------------------------------------------------------
    // Checks.
    // ------------------------------------------------------------------------

    // Writes belong to a live store or swap request.
    aWrOnlyInWrite : assert property (@(posedge i_clk) disable iff (i_rst)
        o_memWr |-> i_dReq.en && (i_dReq.wr || i_dReq.swp))
        else $error("Memory write outside a requested write cycle.");

    // Status never finishes an access nobody asked for.
    aDoneNeedsEn : assert property (@(posedge i_clk) disable iff (i_rst)
        o_dStat.done |-> i_dReq.en)
        else $error("Data done without a request.");

    // Memory answers every read cycle with a defined word.
    aReadDefined : assert property (@(posedge i_clk) disable iff (i_rst)
        o_dStat.reading |-> !$isunknown(i_memRData))
        else $error("Unknown read data in a data read cycle.");

endmodule

//--- rtl/coreIsaPkg.sv
package coreIsaPkg;

    import coreBusPkg::*;

    // ------------------------------------------------------------------------
    // Instruction word layout.
    // ------------------------------------------------------------------------

    // Opcode sits in the top nibble of the word.
    localparam int OPCODE_W = 4;

    // Remaining bits carry an address or a pause identifier.
    localparam int FIELD_W = WORD_W - OPCODE_W;

    // Decoded opcodes, anything else runs as NOP.
    typedef enum logic [OPCODE_W-1:0] {
        OP_NOP = 4'h0,
        OP_SWP = 4'h1,
        OP_PSE = 4'h3,
        OP_STR = 4'h4,
        OP_LDR = 4'h5
    } opcode_e;

    // Memory view (LDR, STR, SWP).
    typedef struct packed {
        opcode_e            op;
        logic [FIELD_W-1:0] addr;
    } memView_t;

    // Pause view (PSE), id is handed to the MCU.
    typedef struct packed {
        opcode_e            op;
        logic [FIELD_W-1:0] id;
    } pauseView_t;

    // One instruction word, read through either view.
    typedef union packed {
        memView_t   mem;
        pauseView_t pause;
    } instr_u;

    // ------------------------------------------------------------------------
    // Pipeline register between FETCH and EXECUTE/MEMORY.
    // ------------------------------------------------------------------------

    typedef struct packed {
        // Entry is a bubble, opcode reads as NOP.
        logic              clear;
        // Address following the fetched instruction.
        logic [ADDR_W-1:0] pcNext;
        instr_u            instr;
    } pipeReg_t;

    // Bubble loaded at reset and during boot.
    localparam pipeReg_t PIPE_CLEARED = pipeReg_t'({1'b1, {(ADDR_W + WORD_W){1'b0}}});

endpackage

//--- rtl/coreBusPkg.sv
package coreBusPkg;

    // ------------------------------------------------------------------------
    // Bus dimensions.
    // ------------------------------------------------------------------------

    // Width of one memory word.
    localparam int WORD_W = 16;

    // Full word address width carried on the external bus.
    localparam int ADDR_W = 15;

    // ------------------------------------------------------------------------
    // Data port between the execute stage and the memory controller.
    // ------------------------------------------------------------------------

    // Data access request, held as a level while the instruction waits.
    typedef struct packed {
        // Request is active.
        logic              en;
        // Plain store (single write cycle).
        logic              wr;
        // Exchange (read cycle, then write cycle).
        logic              swp;
        // Word address of the data access.
        logic [ADDR_W-1:0] addr;
        // Word to write on the write cycle.
        logic [WORD_W-1:0] wdata;
    } dataReq_t;

    // Data access status returned by the controller.
    typedef struct packed {
        // Read word on the bus is valid this cycle.
        logic reading;
        // Last cycle of the access.
        logic done;
    } dataStat_t;

endpackage
